// ==== include/sys_params.svh ====
`ifndef SYS_PARAMS_SVH
`define SYS_PARAMS_SVH

// bus widths
`define SYS_ADDR_W          32
`define SYS_DATA_W          32
`define SYS_SEL_W           4

// slave row
`define SYS_NUM_SLAVES      4
`define SYS_IDX_W           $clog2(`SYS_NUM_SLAVES)
// word registers per slave, addressed by adr[3:2]
`define SYS_REGS_PER_SLAVE  4

// ----------------------------------------------------------
// address map
// ----------------------------------------------------------
// region field picks the slave
`define SYS_REGION_MSB      27
`define SYS_REGION_LSB      24
// tag in adr[31:28] marks the register space
`define SYS_PERIPH_TAG      1

`endif

// ==== design/sys_pkg.sv ====
`include "sys_params.svh"

package sys_pkg;

    // ----------------------------------------------------------
    // encodings
    // ----------------------------------------------------------
    // bus direction, matches the classic we bit
    typedef enum logic {
        WB_READ  = 1'b0,
        WB_WRITE = 1'b1
    } wb_op_e;

    // decoder holds one request at a time
    typedef enum logic {
        DEC_IDLE = 1'b0,
        DEC_BUSY = 1'b1
    } dec_state_e;

    // ----------------------------------------------------------
    // bus bundles
    // ----------------------------------------------------------
    // master to slave, 69 bits
    typedef struct packed {
        logic [`SYS_ADDR_W-1:0] adr;
        logic [`SYS_SEL_W-1:0]  sel;
        wb_op_e                 op;
        logic [`SYS_DATA_W-1:0] wdat;
    } wb_req_t;

    // slave to master, 34 bits
    typedef struct packed {
        logic [`SYS_DATA_W-1:0] rdat;
        logic                   ack;
        logic                   err;
    } wb_rsp_t;

endpackage

// ==== design/wb_addr_decoder.sv ====
`timescale 1ns/1ps
`include "sys_params.svh"

module wb_addr_decoder (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_cyc,
    input  logic                        i_stb,
    input  sys_pkg::wb_req_t            i_req,
    input  logic                        i_done,
    output sys_pkg::wb_req_t            o_req,
    output logic [`SYS_NUM_SLAVES-1:0]  o_slv_stb,
    output logic [`SYS_IDX_W-1:0]       o_sel_idx,
    output logic                        o_unmapped,
    output logic                        o_unmapped_vld
);

    localparam int REGION_W = `SYS_REGION_MSB - `SYS_REGION_LSB + 1;
    localparam int TAG_W    = `SYS_ADDR_W - `SYS_REGION_MSB - 1;

    sys_pkg::dec_state_e          state;
    logic                         accept;
    logic [TAG_W-1:0]             tag;
    logic [REGION_W-1:0]          region;
    logic                         mapped;
    logic [`SYS_NUM_SLAVES-1:0]   stb_dec;
    logic [`SYS_IDX_W-1:0]        idx_dec;

    // ----------------------------------------------------------
    // address decode, straight off the master bus
    // ----------------------------------------------------------
    assign tag    = i_req.adr[`SYS_ADDR_W-1:`SYS_REGION_MSB+1];
    assign region = i_req.adr[`SYS_REGION_MSB:`SYS_REGION_LSB];
    // wrong tag or region past the last slave goes to err
    assign mapped = (tag == TAG_W'(`SYS_PERIPH_TAG)) && (region < `SYS_NUM_SLAVES);

    always_comb begin
        stb_dec = '0;
        idx_dec = '0;
        if (mapped) begin
            idx_dec          = region[`SYS_IDX_W-1:0];
            stb_dec[idx_dec] = 1'b1;
        end
    end

    // only one request in flight, held stb is ignored while busy
    assign accept = (state == sys_pkg::DEC_IDLE) && i_cyc && i_stb;

    // ----------------------------------------------------------
    // control FSM
    // ----------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state          <= sys_pkg::DEC_IDLE;
            o_slv_stb      <= '0;
            o_sel_idx      <= '0;
            o_unmapped     <= 1'b0;
            o_unmapped_vld <= 1'b0;
        end else begin
            // strobes and valid are single cycle pulses
            o_slv_stb      <= '0;
            o_unmapped_vld <= 1'b0;
            case (state)
                sys_pkg::DEC_IDLE: begin
                    if (accept) begin
                        state          <= sys_pkg::DEC_BUSY;
                        o_slv_stb      <= stb_dec;
                        o_sel_idx      <= idx_dec;
                        // level flag, held for the whole transfer
                        o_unmapped     <= ~mapped;
                        o_unmapped_vld <= 1'b1;
                    end
                end
                sys_pkg::DEC_BUSY: begin
                    // free again once the mux has answered
                    if (i_done) begin
                        state <= sys_pkg::DEC_IDLE;
                    end
                end
                default: state <= sys_pkg::DEC_IDLE;
            endcase
        end
    end

    // request copy for the slaves
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_req <= i_req;
        end
    end

endmodule

// ==== design/wb_reg_slave.sv ====
`timescale 1ns/1ps
`include "sys_params.svh"

module wb_reg_slave (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_stb,
    input  sys_pkg::wb_req_t  i_req,
    output sys_pkg::wb_rsp_t  o_rsp
);

    localparam int WIDX_W   = $clog2(`SYS_REGS_PER_SLAVE);
    localparam int NUM_BYTE = `SYS_SEL_W;

    logic [`SYS_DATA_W-1:0] regs [`SYS_REGS_PER_SLAVE];
    logic [WIDX_W-1:0]      widx;
    logic                   wr_en;
    logic                   rd_en;
    logic                   ack_q;
    logic [`SYS_DATA_W-1:0] rdat_q;

    // ----------------------------------------------------------
    // access decode
    // ----------------------------------------------------------
    // word index sits just above the byte offset
    assign widx  = i_req.adr[2 +: WIDX_W];
    assign wr_en = i_stb && (i_req.op == sys_pkg::WB_WRITE);
    assign rd_en = i_stb && (i_req.op == sys_pkg::WB_READ);

    // ----------------------------------------------------------
    // register bank
    // ----------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int r = 0; r < `SYS_REGS_PER_SLAVE; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            // byte lanes with sel low keep their old value
            for (int b = 0; b < NUM_BYTE; b++) begin
                if (i_req.sel[b]) begin
                    regs[widx][8*b +: 8] <= i_req.wdat[8*b +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // response, one cycle after the strobe
    // ----------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q <= 1'b0;
        end else begin
            // reads and writes both ack
            ack_q <= i_stb;
        end
    end

    // full word on read, zero on write
    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            rdat_q <= regs[widx];
        end else if (wr_en) begin
            rdat_q <= '0;
        end
    end

    assign o_rsp.rdat = rdat_q;
    assign o_rsp.ack  = ack_q;
    // plain registers never fail
    assign o_rsp.err  = 1'b0;

endmodule

// ==== design/wb_resp_mux.sv ====
`timescale 1ns/1ps
`include "sys_params.svh"

module wb_resp_mux (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  sys_pkg::wb_rsp_t       i_slv_rsp [`SYS_NUM_SLAVES],
    input  logic [`SYS_IDX_W-1:0]  i_sel_idx,
    input  logic                   i_unmapped,
    input  logic                   i_unmapped_vld,
    output sys_pkg::wb_rsp_t       o_rsp,
    output logic                   o_done
);

    sys_pkg::wb_rsp_t        sel_rsp;
    logic                    err_pend;
    logic                    ack_q;
    logic                    err_q;
    logic [`SYS_DATA_W-1:0]  rdat_q;

    // ----------------------------------------------------------
    // slave select
    // ----------------------------------------------------------
    // index is held by the decoder for the whole transfer
    assign sel_rsp = i_slv_rsp[i_sel_idx];

    // ----------------------------------------------------------
    // response register
    // ----------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            err_pend <= 1'b0;
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            // stand-in for the slave stage on unmapped requests
            err_pend <= i_unmapped_vld & i_unmapped;
            // no slave was strobed, so mask its ack
            ack_q    <= sel_rsp.ack & ~i_unmapped;
            err_q    <= err_pend | (sel_rsp.err & ~i_unmapped);
        end
    end

    // read data, zero with an err
    always_ff @(posedge i_clk) begin
        if (i_unmapped) begin
            rdat_q <= '0;
        end else begin
            rdat_q <= sel_rsp.rdat;
        end
    end

    assign o_rsp.rdat = rdat_q;
    assign o_rsp.ack  = ack_q;
    assign o_rsp.err  = err_q;

    // tells the decoder the transfer is over
    assign o_done = ack_q | err_q;

endmodule

// ==== design/wb_system_top.sv ====
`timescale 1ns/1ps
`include "sys_params.svh"

module wb_system_top (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_cyc,
    input  logic              i_stb,
    input  sys_pkg::wb_req_t  i_req,
    output sys_pkg::wb_rsp_t  o_rsp
);

    sys_pkg::wb_req_t             slv_req;
    logic [`SYS_NUM_SLAVES-1:0]   slv_stb;
    sys_pkg::wb_rsp_t             slv_rsp [`SYS_NUM_SLAVES];
    logic [`SYS_IDX_W-1:0]        sel_idx;
    logic                         unmapped;
    logic                         unmapped_vld;
    logic                         done;

    // ----------------------------------------------------------
    // address decoder, the single master enters here
    // ----------------------------------------------------------
    wb_addr_decoder u_decoder (
        .i_clk          ( i_clk        ),
        .i_arst_n       ( i_arst_n     ),
        .i_cyc          ( i_cyc        ),
        .i_stb          ( i_stb        ),
        .i_req          ( i_req        ),
        .i_done         ( done         ),
        .o_req          ( slv_req      ),
        .o_slv_stb      ( slv_stb      ),
        .o_sel_idx      ( sel_idx      ),
        .o_unmapped     ( unmapped     ),
        .o_unmapped_vld ( unmapped_vld )
    );

    // ----------------------------------------------------------
    // register slaves, one per region
    // ----------------------------------------------------------
    for (genvar s = 0; s < `SYS_NUM_SLAVES; s++) begin : g_slave
        wb_reg_slave u_slave (
            .i_clk    ( i_clk      ),
            .i_arst_n ( i_arst_n   ),
            .i_stb    ( slv_stb[s] ),
            .i_req    ( slv_req    ),
            .o_rsp    ( slv_rsp[s] )
        );
    end

    // response back to the master
    wb_resp_mux u_resp_mux (
        .i_clk          ( i_clk        ),
        .i_arst_n       ( i_arst_n     ),
        .i_slv_rsp      ( slv_rsp      ),
        .i_sel_idx      ( sel_idx      ),
        .i_unmapped     ( unmapped     ),
        .i_unmapped_vld ( unmapped_vld ),
        .o_rsp          ( o_rsp        ),
        .o_done         ( done         )
    );

endmodule

// ==== tb/wb_system_chk.sv ====
`timescale 1ns/1ps

module wb_system_chk (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic                 i_cyc,
    input  logic                 i_stb,
    input  sys_pkg::wb_rsp_t     i_rsp,
    input  sys_pkg::dec_state_e  i_dec_state
);

    int unsigned n_fail = 0;
    logic        accept;
    logic        rsp_any;
    logic        pending;

    // acceptance as the decoder sees it
    assign accept  = i_cyc && i_stb && (i_dec_state == sys_pkg::DEC_IDLE);
    assign rsp_any = i_rsp.ack || i_rsp.err;

    // one request in flight until its answer
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (rsp_any) begin
            pending <= 1'b0;
        end
    end

    // ----------------------------------------------------------
    // protocol properties
    // ----------------------------------------------------------
    a_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_rsp.ack && i_rsp.err))
        else begin
            n_fail++;
            $error("ack and err high together");
        end

    // answer lands exactly 3 cycles after acceptance
    a_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        accept |-> ##1 !rsp_any ##1 !rsp_any ##1 (i_rsp.ack ^ i_rsp.err))
        else begin
            n_fail++;
            $error("accepted request not answered 3 cycles later");
        end

    a_rst_held: assert property (@(posedge i_clk) !i_arst_n |-> !rsp_any)
        else begin
            n_fail++;
            $error("response during reset");
        end

    a_rst_release: assert property (@(posedge i_clk) $rose(i_arst_n) |-> !rsp_any)
        else begin
            n_fail++;
            $error("response right after reset release");
        end

    // a second answer without a new acceptance
    a_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rsp_any |-> pending)
        else begin
            n_fail++;
            $error("response with no request in flight");
        end

endmodule

bind wb_system_top wb_system_chk u_chk (
    .i_clk       ( i_clk           ),
    .i_arst_n    ( i_arst_n        ),
    .i_cyc       ( i_cyc           ),
    .i_stb       ( i_stb           ),
    .i_rsp       ( o_rsp           ),
    .i_dec_state ( u_decoder.state )
);

// ==== tb/tb_wb_system.sv ====
`timescale 1ns/1ps
`include "sys_params.svh"

module tb_wb_system;

    localparam int NS = `SYS_NUM_SLAVES;
    localparam int NR = `SYS_REGS_PER_SLAVE;
    // requests per test 16, 32, 32, 20, 28, 16
    localparam int NUM_REQ = 144;
    localparam int RST_CYC = 8;

    logic                   i_clk;
    logic                   i_arst_n;
    logic                   i_cyc;
    logic                   i_stb;
    sys_pkg::wb_req_t       i_req;
    sys_pkg::wb_rsp_t       o_rsp;
    logic [15:0]            lfsr;
    logic [`SYS_DATA_W-1:0] ref_mem [NS][NR];
    int unsigned            n_tests;
    int unsigned            n_checks;
    int unsigned            n_errs;
    int unsigned            test_errs;

    wb_system_top i_dut (
        .i_clk    ( i_clk    ),
        .i_arst_n ( i_arst_n ),
        .i_cyc    ( i_cyc    ),
        .i_stb    ( i_stb    ),
        .i_req    ( i_req    ),
        .o_rsp    ( o_rsp    )
    );

    always #10 i_clk = ~i_clk;

    // watchdog allows ten cycles per request plus reset
    initial begin
        #((NUM_REQ * 10 + RST_CYC) * 20);
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("=== FAIL ===");
        $finish;
    end

    // ----------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------
    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [`SYS_ADDR_W-1:0] make_adr(int tag, int region, int word);
        logic [`SYS_ADDR_W-1:0] a;
        a = '0;
        a[`SYS_ADDR_W-1:`SYS_REGION_MSB+1]   = tag[3:0];
        a[`SYS_REGION_MSB:`SYS_REGION_LSB] = region[3:0];
        a[3:2] = word[1:0];
        return a;
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        n_checks++;
        assert (act === exp) else begin
            n_errs++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // one classic cycle with stb held until ack or err
    task automatic xfer(string name, sys_pkg::wb_op_e op, logic [31:0] adr, logic [3:0] sel,
                        logic [31:0] wdat, output logic [31:0] rdat, output logic [1:0] flags);
        int n;
        n = 0;
        @(posedge i_clk);
        #1;
        i_cyc = 1'b1;
        i_stb = 1'b1;
        i_req = '{adr: adr, sel: sel, op: op, wdat: wdat};
        do begin
            @(posedge i_clk);
            #1;
            n++;
        end while (!(o_rsp.ack || o_rsp.err) && n < 20);
        if (!(o_rsp.ack || o_rsp.err)) begin
            n_errs++;
            $display("%s: the bus gave no response within 20 cycles", name);
        end
        rdat  = o_rsp.rdat;
        flags = {o_rsp.ack, o_rsp.err};
        i_cyc = 1'b0;
        i_stb = 1'b0;
    endtask

    // write and mirror it in the reference copy
    task automatic wr(string name, int s, int r, logic [3:0] sel, logic [31:0] d);
        logic [31:0] rd;
        logic [1:0]  fl;
        xfer(name, sys_pkg::WB_WRITE, make_adr(`SYS_PERIPH_TAG, s, r), sel, d, rd, fl);
        check({name, " ack"}, 32'b10, 32'(fl));
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                ref_mem[s][r][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic rd_check(string name, int s, int r);
        logic [31:0] rd;
        logic [1:0]  fl;
        xfer(name, sys_pkg::WB_READ, make_adr(`SYS_PERIPH_TAG, s, r), 4'hf, '0, rd, fl);
        check({name, " ack"}, 32'b10, 32'(fl));
        check({name, " data"}, ref_mem[s][r], rd);
    endtask

    task automatic check_all(string name);
        for (int s = 0; s < NS; s++) begin
            for (int r = 0; r < NR; r++) begin
                rd_check(name, s, r);
            end
        end
    endtask

    // unmapped write then read that must both err
    task automatic bad(string name, int tag, int region);
        logic [31:0] rd;
        logic [1:0]  fl;
        xfer(name, sys_pkg::WB_WRITE, make_adr(tag, region, 1), 4'hf, rand_bits(32), rd, fl);
        check({name, " write err"}, 32'b01, 32'(fl));
        xfer(name, sys_pkg::WB_READ, make_adr(tag, region, 1), 4'hf, '0, rd, fl);
        check({name, " read err"}, 32'b01, 32'(fl));
        check({name, " read data"}, '0, rd);
    endtask

    task automatic end_test(string name);
        n_tests++;
        $display("test %0d %s: %s, %0d errors", n_tests, name,
                 (n_errs == test_errs) ? "ok" : "FAILED", n_errs - test_errs);
        test_errs = n_errs;
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        int s;
        int r;
        i_clk    = 1'b0;
        i_arst_n = 1'b0;
        i_cyc    = 1'b0;
        i_stb    = 1'b0;
        i_req    = '0;
        lfsr     = 16'd3261;
        n_tests  = 0;
        n_checks = 0;
        n_errs   = 0;
        test_errs = 0;
        foreach (ref_mem[a, b]) ref_mem[a][b] = '0;
        repeat (RST_CYC) @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;

        check_all("reset_zero");
        end_test("reset_zero");
        foreach (ref_mem[a, b]) wr("full_word", a, b, 4'hf, rand_bits(32));
        check_all("full_word");
        end_test("full_word");
        foreach (ref_mem[a, b]) wr("byte_sel", a, b, 4'(rand_bits(4)), rand_bits(32));
        check_all("byte_sel");
        end_test("byte_sel");
        // same register in the other slaves must not move
        for (int k = 0; k < NS; k++) begin
            wr("isolation", k, 1, 4'hf, rand_bits(32));
            for (int t = 0; t < NS; t++) begin
                rd_check("isolation", t, 1);
            end
        end
        end_test("isolation");
        // wrong tags first and then regions past the last slave
        bad("unmapped", 0, 0);
        bad("unmapped", 2, 1);
        bad("unmapped", 15, 3);
        bad("unmapped", `SYS_PERIPH_TAG, NS);
        bad("unmapped", `SYS_PERIPH_TAG, 7);
        bad("unmapped", `SYS_PERIPH_TAG, 15);
        check_all("unmapped");
        end_test("unmapped");
        for (int k = 0; k < 8; k++) begin
            s = rand_bits(2);
            r = rand_bits(2);
            wr("back_to_back", s, r, 4'hf, rand_bits(32));
            rd_check("back_to_back", s, r);
        end
        end_test("back_to_back");

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_tests, n_checks, n_errs, i_dut.u_chk.n_fail);
        if (n_errs == 0 && i_dut.u_chk.n_fail == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
design/sys_pkg.sv
design/wb_addr_decoder.sv
design/wb_reg_slave.sv
design/wb_resp_mux.sv
design/wb_system_top.sv
tb/wb_system_chk.sv
tb/tb_wb_system.sv
